// File: logic/udp_echo_pkg.sv
/* UDP echo shared types and constants */

package udp_echo_pkg;

    // Decoded UDP header with its IP addresses
    typedef struct packed {
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] port_src;
        logic [15:0] port_dst;
        logic [15:0] length;
        logic [7:0]  ttl;
    } udp_hdr_t;

    // One payload byte with user as the error mark
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

    // Wishbone classic request from the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Live echo configuration
    typedef struct packed {
        logic [31:0] local_ip;
        logic [15:0] echo_port;
        logic [7:0]  ttl;
    } echo_cfg_t;

    // Reset values of the echo settings
    localparam logic [31:0] DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd100, 8'd128};
    localparam logic [15:0] DEFAULT_ECHO_PORT = 16'd1234;
    localparam logic [7:0] DEFAULT_TTL = 8'd64;

    // FIFO depths as powers of two
    localparam int PAYLOAD_FIFO_DEPTH = 64;
    localparam int HDR_FIFO_DEPTH = 4;

    // Register map
    localparam logic [2:0] REG_LOCAL_IP = 3'd0;
    localparam logic [2:0] REG_ECHO_PORT = 3'd1;
    localparam logic [2:0] REG_TTL = 3'd2;
    localparam logic [2:0] REG_ECHO_COUNT = 3'd3;
    localparam logic [2:0] REG_DROP_COUNT = 3'd4;

endpackage

// File: logic/stream_fifo.sv
/* Synchronous valid/ready FIFO */

`timescale 1ns/1ps

module stream_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    // Full blocks writes even when a read happens in the same cycle
    assign in_ready = (count != (AW + 1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/echo_config_regs.sv
/* Echo configuration and frame counters */

`timescale 1ns/1ps

module echo_config_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_echo_pkg::wb_req_t   wb,
    output logic                    wb_ack,
    output logic [31:0]             wb_dat_r,
    output udp_echo_pkg::echo_cfg_t cfg,
    input  logic                    echo_pulse,
    input  logic                    drop_pulse
);

    logic [31:0] echo_count;
    logic [31:0] drop_count;
    logic        access;
    logic [31:0] rd_mux;

    // New cycle seen and not yet acknowledged
    assign access = wb.cyc && wb.stb && !wb_ack;

    always_comb begin
        case (wb.adr)
            udp_echo_pkg::REG_LOCAL_IP: begin
                rd_mux = cfg.local_ip;
            end
            udp_echo_pkg::REG_ECHO_PORT: begin
                rd_mux = {16'd0, cfg.echo_port};
            end
            udp_echo_pkg::REG_TTL: begin
                rd_mux = {24'd0, cfg.ttl};
            end
            udp_echo_pkg::REG_ECHO_COUNT: begin
                rd_mux = echo_count;
            end
            udp_echo_pkg::REG_DROP_COUNT: begin
                rd_mux = drop_count;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            cfg.local_ip <= udp_echo_pkg::DEFAULT_LOCAL_IP;
            cfg.echo_port <= udp_echo_pkg::DEFAULT_ECHO_PORT;
            cfg.ttl <= udp_echo_pkg::DEFAULT_TTL;
            echo_count <= '0;
            drop_count <= '0;
        end else begin
            wb_ack <= access;
            // Counter addresses are read only
            if (access && wb.we) begin
                case (wb.adr)
                    udp_echo_pkg::REG_LOCAL_IP: cfg.local_ip <= wb.dat;
                    udp_echo_pkg::REG_ECHO_PORT: cfg.echo_port <= wb.dat[15:0];
                    udp_echo_pkg::REG_TTL: cfg.ttl <= wb.dat[7:0];
                    default: ;
                endcase
            end
            if (echo_pulse) begin
                echo_count <= echo_count + 32'd1;
            end
            if (drop_pulse) begin
                drop_count <= drop_count + 32'd1;
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

// File: logic/echo_frame_filter.sv
/* UDP echo frame filter */

`timescale 1ns/1ps

module echo_frame_filter (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_echo_pkg::echo_cfg_t cfg,

    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::byte_beat_t rx_beat,
    input  logic                     rx_beat_valid,
    output logic                     rx_beat_ready,

    output udp_echo_pkg::udp_hdr_t   match_hdr,
    output logic                     match_hdr_valid,
    input  logic                     match_hdr_ready,
    output udp_echo_pkg::byte_beat_t pass_beat,
    output logic                     pass_beat_valid,
    input  logic                     pass_beat_ready,

    output logic                     echo_pulse,
    output logic                     drop_pulse
);

    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } state_t;

    state_t state;
    logic   port_match;
    logic   hdr_fire;
    logic   beat_fire;

    assign port_match = (rx_hdr.port_dst == cfg.echo_port);

    // Dropped headers also wait for header FIFO room
    assign rx_hdr_ready = (state == IDLE) && match_hdr_ready;
    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;

    assign match_hdr_valid = (state == IDLE) && rx_hdr_valid && port_match;
    assign echo_pulse = hdr_fire && port_match;
    assign drop_pulse = hdr_fire && !port_match;

    // Turned-around header
    always_comb begin
        match_hdr.ip_src = cfg.local_ip;
        match_hdr.ip_dst = rx_hdr.ip_src;
        match_hdr.port_src = rx_hdr.port_dst;
        match_hdr.port_dst = rx_hdr.port_src;
        match_hdr.length = rx_hdr.length;
        match_hdr.ttl = cfg.ttl;
    end

    // Payload goes to the FIFO in pass and is swallowed in drop
    assign pass_beat = rx_beat;
    assign pass_beat_valid = (state == PASS) && rx_beat_valid;
    assign rx_beat_ready = ((state == PASS) && pass_beat_ready) || (state == DROP);
    assign beat_fire = rx_beat_valid && rx_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_fire) begin
                        state <= port_match ? PASS : DROP;
                    end
                end
                PASS, DROP: begin
                    // Frame ends on the accepted last beat
                    if (beat_fire && rx_beat.last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/udp_echo_top.sv
/* UDP echo top level */

`timescale 1ns/1ps

module udp_echo_top (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::wb_req_t    wb,
    output logic                     wb_ack,
    output logic [31:0]              wb_dat_r,

    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::byte_beat_t rx_beat,
    input  logic                     rx_beat_valid,
    output logic                     rx_beat_ready,

    output udp_echo_pkg::udp_hdr_t   tx_hdr,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::byte_beat_t tx_beat,
    output logic                     tx_beat_valid,
    input  logic                     tx_beat_ready
);

    udp_echo_pkg::echo_cfg_t  cfg;
    logic                     echo_pulse;
    logic                     drop_pulse;
    udp_echo_pkg::udp_hdr_t   match_hdr;
    logic                     match_hdr_valid;
    logic                     match_hdr_ready;
    udp_echo_pkg::byte_beat_t pass_beat;
    logic                     pass_beat_valid;
    logic                     pass_beat_ready;

    echo_config_regs regs_i (
        .clk        (clk),
        .rst        (rst),
        .wb         (wb),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .cfg        (cfg),
        .echo_pulse (echo_pulse),
        .drop_pulse (drop_pulse)
    );

    echo_frame_filter filter_i (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .rx_hdr          (rx_hdr),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_beat         (rx_beat),
        .rx_beat_valid   (rx_beat_valid),
        .rx_beat_ready   (rx_beat_ready),
        .match_hdr       (match_hdr),
        .match_hdr_valid (match_hdr_valid),
        .match_hdr_ready (match_hdr_ready),
        .pass_beat       (pass_beat),
        .pass_beat_valid (pass_beat_valid),
        .pass_beat_ready (pass_beat_ready),
        .echo_pulse      (echo_pulse),
        .drop_pulse      (drop_pulse)
    );

    // Echo headers waiting for transmit
    stream_fifo #(
        .T     (udp_echo_pkg::udp_hdr_t),
        .DEPTH (udp_echo_pkg::HDR_FIFO_DEPTH)
    ) hdr_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (match_hdr),
        .in_valid  (match_hdr_valid),
        .in_ready  (match_hdr_ready),
        .out_data  (tx_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready)
    );

    stream_fifo #(
        .T     (udp_echo_pkg::byte_beat_t),
        .DEPTH (udp_echo_pkg::PAYLOAD_FIFO_DEPTH)
    ) payload_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pass_beat),
        .in_valid  (pass_beat_valid),
        .in_ready  (pass_beat_ready),
        .out_data  (tx_beat),
        .out_valid (tx_beat_valid),
        .out_ready (tx_beat_ready)
    );

endmodule

// File: tests/udp_echo_ref.svh
/* UDP echo reference model */

`ifndef UDP_ECHO_REF_SVH
`define UDP_ECHO_REF_SVH

// Header expected back for a received header under a given configuration
function automatic udp_echo_pkg::udp_hdr_t expected_echo_hdr(
    input udp_echo_pkg::udp_hdr_t  rx,
    input udp_echo_pkg::echo_cfg_t cfg
);
    udp_echo_pkg::udp_hdr_t h;
    h.ip_src = cfg.local_ip;
    h.ip_dst = rx.ip_src;
    h.port_src = rx.port_dst;
    h.port_dst = rx.port_src;
    h.length = rx.length;
    h.ttl = cfg.ttl;
    return h;
endfunction

// Only the destination port decides
function automatic bit is_echo(
    input udp_echo_pkg::udp_hdr_t  rx,
    input udp_echo_pkg::echo_cfg_t cfg
);
    return rx.port_dst == cfg.echo_port;
endfunction

`endif

// File: tests/udp_echo_tb.sv
/* UDP echo testbench */

`timescale 1ns/1ps

module udp_echo_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_RANDOM = 40;
    localparam int TOTAL_FRAMES = NUM_RANDOM + 6;

    logic clk;
    logic rst;
    udp_echo_pkg::wb_req_t wb;
    logic wb_ack;
    logic [31:0] wb_dat_r;
    udp_echo_pkg::udp_hdr_t rx_hdr;
    logic rx_hdr_valid;
    logic rx_hdr_ready;
    udp_echo_pkg::byte_beat_t rx_beat;
    logic rx_beat_valid;
    logic rx_beat_ready;
    udp_echo_pkg::udp_hdr_t tx_hdr;
    logic tx_hdr_valid;
    logic tx_hdr_ready;
    udp_echo_pkg::byte_beat_t tx_beat;
    logic tx_beat_valid;
    logic tx_beat_ready;

    udp_echo_pkg::echo_cfg_t model_cfg;
    udp_echo_pkg::udp_hdr_t exp_hdr_q[$];
    udp_echo_pkg::byte_beat_t exp_beat_q[$];
    udp_echo_pkg::udp_hdr_t want_hdr;
    udp_echo_pkg::byte_beat_t want_beat;
    int exp_echo = 0;
    int exp_drop = 0;
    int reg_errors = 0;
    int stream_errors = 0;
    bit random_ready = 1'b0;

    `include "udp_echo_ref.svh"

    udp_echo_top udp_echo_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Tasks start and end right after a rising edge
    task automatic write_reg(input logic [2:0] adr, input logic [31:0] dat);
        wb <= {1'b1, 1'b1, 1'b1, adr, dat};
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb <= '0;
        @(posedge clk);
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [31:0] dat);
        wb <= {1'b1, 1'b1, 1'b0, adr, 32'd0};
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        dat = wb_dat_r;
        @(posedge clk);
        wb <= '0;
        @(posedge clk);
    endtask

    task automatic check_reg(input logic [2:0] adr, input logic [31:0] want);
        logic [31:0] got;
        read_reg(adr, got);
        if (got !== want) begin
            $display("Error at %0t: register %0d read %h, expected %h", $time, adr, got, want);
            reg_errors++;
        end
    endtask

    task automatic send_frame(input logic [15:0] port, input int len);
        udp_echo_pkg::udp_hdr_t h;
        udp_echo_pkg::byte_beat_t b;
        bit echo;
        h.ip_src = $urandom;
        h.ip_dst = $urandom;
        h.port_src = 16'($urandom);
        h.port_dst = port;
        h.length = 16'(len + 8);
        h.ttl = 8'($urandom);
        echo = is_echo(h, model_cfg);
        if (echo) begin
            exp_hdr_q.push_back(expected_echo_hdr(h, model_cfg));
            exp_echo++;
        end else begin
            exp_drop++;
        end
        rx_hdr <= h;
        rx_hdr_valid <= 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) @(negedge clk);
        @(posedge clk);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < len; i++) begin
            b.data = 8'($urandom);
            b.last = (i == len - 1);
            b.user = ($urandom_range(0, 7) == 0);
            if (echo) begin
                exp_beat_q.push_back(b);
            end
            rx_beat <= b;
            rx_beat_valid <= 1'b1;
            @(negedge clk);
            while (!rx_beat_ready) @(negedge clk);
            @(posedge clk);
        end
        rx_beat_valid <= 1'b0;
    endtask

    // Transmit side back-pressure
    initial begin
        tx_hdr_ready = 1'b1;
        tx_beat_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (random_ready) begin
                tx_hdr_ready <= 1'($urandom);
                tx_beat_ready <= ($urandom_range(0, 3) != 0);
            end else begin
                tx_hdr_ready <= 1'b1;
                tx_beat_ready <= 1'b1;
            end
        end
    end

    // A transfer seen here completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            if (exp_hdr_q.size() == 0) begin
                $display("Unexpected tx header at %0t with no echo frame pending", $time);
                stream_errors++;
            end else begin
                want_hdr = exp_hdr_q.pop_front();
                if (tx_hdr !== want_hdr) begin
                    $display("Error at %0t: tx header %h, expected %h", $time, tx_hdr, want_hdr);
                    stream_errors++;
                end
            end
        end
        if (!rst && tx_beat_valid && tx_beat_ready) begin
            if (exp_beat_q.size() == 0) begin
                $display("Unexpected tx beat at %0t with no echo payload pending", $time);
                stream_errors++;
            end else begin
                want_beat = exp_beat_q.pop_front();
                if (tx_beat !== want_beat) begin
                    $display("Error at %0t: tx beat %h, expected %h", $time, tx_beat, want_beat);
                    stream_errors++;
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (400 * TOTAL_FRAMES + 2000));
        $display("Timeout: the run did not finish within the cycle budget");
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(52559));
        rst = 1'b1;
        wb = '0;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_beat = '0;
        rx_beat_valid = 1'b0;
        model_cfg.local_ip = {8'd192, 8'd168, 8'd100, 8'd128};
        model_cfg.echo_port = 16'd1234;
        model_cfg.ttl = 8'd64;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Defaults after reset
        check_reg(udp_echo_pkg::REG_LOCAL_IP, model_cfg.local_ip);
        check_reg(udp_echo_pkg::REG_ECHO_PORT, 32'(model_cfg.echo_port));
        check_reg(udp_echo_pkg::REG_TTL, 32'(model_cfg.ttl));
        check_reg(udp_echo_pkg::REG_ECHO_COUNT, 32'd0);
        check_reg(udp_echo_pkg::REG_DROP_COUNT, 32'd0);
        check_reg(3'd6, 32'd0);

        send_frame(16'd1234, 6);
        send_frame(16'd80, 5);
        send_frame(16'd1234, 3);

        // New settings through the bus
        model_cfg.local_ip = 32'h0a00_0001;
        model_cfg.echo_port = 16'd7777;
        model_cfg.ttl = 8'd32;
        write_reg(udp_echo_pkg::REG_LOCAL_IP, model_cfg.local_ip);
        write_reg(udp_echo_pkg::REG_ECHO_PORT, 32'(model_cfg.echo_port));
        write_reg(udp_echo_pkg::REG_TTL, 32'(model_cfg.ttl));
        write_reg(udp_echo_pkg::REG_ECHO_COUNT, 32'hdead_beef);
        check_reg(udp_echo_pkg::REG_LOCAL_IP, model_cfg.local_ip);
        check_reg(udp_echo_pkg::REG_ECHO_PORT, 32'(model_cfg.echo_port));
        check_reg(udp_echo_pkg::REG_TTL, 32'(model_cfg.ttl));
        send_frame(16'd7777, 4);
        send_frame(16'd1234, 4);
        send_frame(16'd7777, 1);

        random_ready <= 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_frame(($urandom_range(0, 1) == 1) ? model_cfg.echo_port : 16'($urandom),
                       $urandom_range(1, 24));
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) @(posedge clk);
        random_ready <= 1'b0;
        repeat (20) @(posedge clk);

        check_reg(udp_echo_pkg::REG_ECHO_COUNT, 32'(exp_echo));
        check_reg(udp_echo_pkg::REG_DROP_COUNT, 32'(exp_drop));

        $display("Register errors: %0d, stream errors: %0d", reg_errors, stream_errors);
        if (reg_errors == 0 && stream_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+tests
logic/udp_echo_pkg.sv
logic/stream_fifo.sv
logic/echo_config_regs.sv
logic/echo_frame_filter.sv
logic/udp_echo_top.sv
tests/udp_echo_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = udp_echo_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
